//--- pll_reconfig_pkg.sv
`default_nettype none

package pll_reconfig_pkg;

	////////////////////////////////////////////////////////////
	// Register port words

	localparam int drp_addr_w = 7;
	localparam int drp_data_w = 16;

	typedef logic [drp_data_w-1:0] drp_word_t;
	typedef logic [drp_addr_w-1:0] drp_addr_t;

	////////////////////////////////////////////////////////////
	// PLL register map

	localparam drp_addr_t reg_power      = 7'h28;
	localparam drp_addr_t reg_clkfbout_1 = 7'h14;
	localparam drp_addr_t reg_clkfbout_2 = 7'h15;
	localparam drp_addr_t reg_indiv      = 7'h16;
	localparam drp_addr_t reg_lock_1     = 7'h18;
	localparam drp_addr_t reg_lock_2     = 7'h19;
	localparam drp_addr_t reg_lock_3     = 7'h1a;
	localparam drp_addr_t reg_filt_1     = 7'h4e;
	localparam drp_addr_t reg_filt_2     = 7'h4f;

	// Output dividers, register 1 then register 2
	localparam drp_addr_t reg_clkout0_1  = 7'h08;
	localparam drp_addr_t reg_clkout0_2  = 7'h09;
	localparam drp_addr_t reg_clkout1_1  = 7'h0a;
	localparam drp_addr_t reg_clkout1_2  = 7'h0b;
	localparam drp_addr_t reg_clkout2_1  = 7'h0c;
	localparam drp_addr_t reg_clkout2_2  = 7'h0d;
	localparam drp_addr_t reg_clkout3_1  = 7'h0e;
	localparam drp_addr_t reg_clkout3_2  = 7'h0f;
	localparam drp_addr_t reg_clkout4_1  = 7'h10;
	localparam drp_addr_t reg_clkout4_2  = 7'h11;
	// Output 5 sits below output 0 in the map
	localparam drp_addr_t reg_clkout5_1  = 7'h06;
	localparam drp_addr_t reg_clkout5_2  = 7'h07;

	////////////////////////////////////////////////////////////
	// Preserve masks, a set bit keeps the old register bit

	localparam drp_word_t mask_clkreg1    = 16'h1000;
	localparam drp_word_t mask_clkfbout_2 = 16'h8000;
	localparam drp_word_t mask_out0_2     = 16'h8000;
	localparam drp_word_t mask_out14_2    = 16'hfc00;
	localparam drp_word_t mask_out5_2     = 16'hc000;
	localparam drp_word_t mask_indiv      = 16'hc000;
	localparam drp_word_t mask_lock_1     = 16'hfc00;
	localparam drp_word_t mask_lock_23    = 16'h8000;
	localparam drp_word_t mask_filt_1     = 16'h66ff;
	localparam drp_word_t mask_filt_2     = 16'h666f;

	// Fixed lock values
	localparam logic [9:0] unlock_cnt    = 10'd1;
	localparam logic [9:0] lock_sat_high = 10'h3e9;

	// Writes per command
	localparam int vco_steps        = 8;
	localparam int out_steps        = 2;
	localparam int lock_table_depth = 64;

	////////////////////////////////////////////////////////////
	// Divider register word, seen as register 1 or register 2

	typedef union packed {
		struct packed {
			logic [2:0] phase_mux;
			logic       rsvd;
			logic [5:0] high_time;
			logic [5:0] low_time;
		} clkreg1;
		struct packed {
			logic [5:0] upper;
			logic [1:0] mx;
			logic       edge_bit;
			logic       no_count;
			logic [5:0] delay;
		} clkreg2;
	} pll_clk_reg_u;

	typedef enum logic [2:0] {
		boot_power,
		boot_hold,
		idle,
		ready,
		vco_write,
		out_write,
		cmd_wait
	} seq_state_e;

	typedef enum logic {
		cmd_vco,
		cmd_out
	} cmd_kind_e;

endpackage

`default_nettype wire

//--- drp_rmw_engine.sv
`timescale 1ns/1ps
`default_nettype none

module drp_rmw_engine import pll_reconfig_pkg::*; (
	input wire            reconfig_clk,
	input wire            reset,
	input wire            reg_wr,
	input wire drp_addr_t reg_addr,
	input wire drp_word_t reg_wdata,
	input wire drp_word_t reg_wmask,
	input wire drp_word_t drp_dout,
	input wire            drp_ready,
	output logic          reg_wr_done,
	output logic          drp_en,
	output logic          drp_we,
	output drp_addr_t     drp_addr,
	output drp_word_t     drp_din
);

	typedef enum logic [1:0] {
		rmw_idle,
		rmw_read,
		rmw_write
	} rmw_state_e;

	rmw_state_e state;
	drp_word_t  merged_word;

	// Old bits under the mask, new bits elsewhere
	assign merged_word = (drp_dout & reg_wmask) | (reg_wdata & ~reg_wmask);

	////////////////////////////////////////////////////////////
	// Access sequencing

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			state       <= rmw_idle;
			drp_en      <= 1'b0;
			drp_we      <= 1'b0;
			reg_wr_done <= 1'b0;
		end else begin
			// Strobes last one cycle
			drp_en      <= 1'b0;
			drp_we      <= 1'b0;
			reg_wr_done <= 1'b0;
			case (state)
				// Request in, read the register first
				rmw_idle: begin
					if (reg_wr) begin
						drp_en <= 1'b1;
						state  <= rmw_read;
					end
				end
				// Read data back, send the merged word
				rmw_read: begin
					if (drp_ready) begin
						drp_en <= 1'b1;
						drp_we <= 1'b1;
						state  <= rmw_write;
					end
				end
				// Write acknowledged
				rmw_write: begin
					if (drp_ready) begin
						reg_wr_done <= 1'b1;
						state       <= rmw_idle;
					end
				end
				default: state <= rmw_idle;
			endcase
		end
	end

	// Address and data
	always_ff @(posedge reconfig_clk) begin
		if (state == rmw_idle && reg_wr)
			drp_addr <= reg_addr;
		if (state == rmw_read && drp_ready)
			drp_din <= merged_word;
	end

endmodule

`default_nettype wire

//--- reconfig_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reconfig_sequencer import pll_reconfig_pkg::*; (
	input wire        reconfig_clk,
	input wire        reset,
	input wire        reconfig_start,
	input wire        reconfig_finish,
	input wire        vco_en,
	input wire        output_en,
	input wire        reg_wr_done,
	input wire        last_step,
	output logic      busy,
	output logic      reconfig_cmd_done,
	output logic      pll_reset,
	output logic      reg_wr,
	output logic      step_load,
	output cmd_kind_e cmd_kind,
	output logic      boot_write
);

	seq_state_e state;

	// Power word selected until the boot write is done
	assign boot_write = busy && (state == boot_power || state == boot_hold);

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			state             <= boot_power;
			busy              <= 1'b1;
			pll_reset         <= 1'b1;
			reconfig_cmd_done <= 1'b0;
			reg_wr            <= 1'b0;
			step_load         <= 1'b0;
			cmd_kind          <= cmd_vco;
		end else begin
			// Single cycle strobes
			reconfig_cmd_done <= 1'b0;
			reg_wr            <= 1'b0;
			step_load         <= 1'b0;

			// PLL released once out of the mode
			if (state == idle)
				pll_reset <= 1'b0;

			case (state)

				////////////////////////////////////////////////////////////
				// Boot

				// Power up every block of the PLL
				boot_power: begin
					reg_wr <= 1'b1;
					state  <= boot_hold;
				end

				// Wait for the power write
				boot_hold: begin
					if (reg_wr_done)
						busy <= 1'b0;
					if (reconfig_start && !busy) begin
						state     <= ready;
						pll_reset <= 1'b1;
					end
				end

				// Out of the mode
				idle: begin
					if (reconfig_start) begin
						state     <= ready;
						pll_reset <= 1'b1;
					end
				end

				////////////////////////////////////////////////////////////
				// Reconfiguration mode

				// Output command takes priority over VCO
				ready: begin
					if (output_en) begin
						cmd_kind  <= cmd_out;
						step_load <= 1'b1;
						state     <= out_write;
					end else if (vco_en) begin
						cmd_kind  <= cmd_vco;
						step_load <= 1'b1;
						state     <= vco_write;
					end else if (reconfig_finish) begin
						state <= idle;
					end
				end

				// Issue the write for the current step
				vco_write, out_write: begin
					reg_wr <= 1'b1;
					state  <= cmd_wait;
				end

				// Counter steps on the same done pulse
				cmd_wait: begin
					if (reg_wr_done) begin
						if (last_step) begin
							reconfig_cmd_done <= 1'b1;
							state             <= ready;
						end else if (cmd_kind == cmd_out) begin
							state <= out_write;
						end else begin
							state <= vco_write;
						end
					end
				end

				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- write_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module write_step_counter import pll_reconfig_pkg::*; (
	input wire            reconfig_clk,
	input wire            reset,
	input wire            step_load,
	input wire cmd_kind_e cmd_kind,
	input wire            reg_wr_done,
	output logic [2:0]    step,
	output logic          last_step
);

	always_ff @(posedge reconfig_clk) begin
		if (reset)
			step <= 3'd0;
		else if (step_load)
			step <= 3'd0;
		// Next register once the current one is written
		else if (reg_wr_done)
			step <= step + 3'd1;
	end

	// Final write depends on the command
	assign last_step = (cmd_kind == cmd_vco) ? (step == 3'(vco_steps - 1)) :
		(step == 3'(out_steps - 1));

endmodule

`default_nettype wire

//--- drp_word_builder.sv
`timescale 1ns/1ps
`default_nettype none

module drp_word_builder import pll_reconfig_pkg::*; (
	input wire            cmd_kind_e cmd_kind,
	input wire [2:0]      step,
	input wire            boot_write,
	input wire [6:0]      vco_mult,
	input wire [6:0]      vco_indiv,
	input wire            vco_bandwidth,
	input wire [2:0]      output_idx,
	input wire [7:0]      output_div,
	input wire [8:0]      output_phase,
	input wire [9:0]      lock_cnt,
	input wire [4:0]      lock_dly,
	input wire [7:0]      filter_lo,
	input wire [7:0]      filter_hi,
	output drp_addr_t     reg_addr,
	output drp_word_t     reg_wdata,
	output drp_word_t     reg_wmask
);

	// High and low counts, low one longer for odd divisors
	function automatic drp_word_t clkreg1_word(input logic [2:0] phase, input logic [7:0] div);
		pll_clk_reg_u w;
		w                   = '0;
		w.clkreg1.phase_mux = phase;
		w.clkreg1.high_time = div[6:1];
		w.clkreg1.low_time  = div[6:1] + 6'(div[0]);
		return w;
	endfunction

	// Edge fixes odd duty cycle, no-count bypasses divide-by-1
	function automatic drp_word_t clkreg2_word(input logic [7:0] div, input logic [5:0] dly);
		pll_clk_reg_u w;
		w                  = '0;
		w.clkreg2.edge_bit = div[0];
		w.clkreg2.no_count = (div == 8'd1);
		w.clkreg2.delay    = dly;
		return w;
	endfunction

	logic [7:0] filter_sel;
	drp_word_t  indiv_word;
	drp_word_t  filt1_word;
	drp_word_t  filt2_word;
	drp_addr_t  out_addr_1;
	drp_addr_t  out_addr_2;
	drp_word_t  out_mask_2;

	assign filter_sel = vco_bandwidth ? filter_hi : filter_lo;

	// Filter bits scattered over two registers
	assign filt1_word = {filter_sel[7], 2'b00, filter_sel[6:5], 2'b00, filter_sel[4], 8'h00};
	assign filt2_word = {filter_sel[3], 2'b00, filter_sel[2:1], 2'b00, filter_sel[0], 8'h00};

	// Input divider packs edge and no-count above the counts
	always_comb begin
		indiv_word     = clkreg1_word(3'd0, {1'b0, vco_indiv});
		indiv_word[13] = vco_indiv[0];
		indiv_word[12] = (vco_indiv == 7'd1);
	end

	////////////////////////////////////////////////////////////
	// Output register pair and its register 2 mask

	always_comb begin
		case (output_idx)
			3'd1: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout1_1, reg_clkout1_2, mask_out14_2};
			3'd2: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout2_1, reg_clkout2_2, mask_out14_2};
			3'd3: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout3_1, reg_clkout3_2, mask_out14_2};
			3'd4: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout4_1, reg_clkout4_2, mask_out14_2};
			3'd5: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout5_1, reg_clkout5_2, mask_out5_2};
			// Output 0, also taken for 6 and 7
			default: {out_addr_1, out_addr_2, out_mask_2} = {reg_clkout0_1, reg_clkout0_2, mask_out0_2};
		endcase
	end

	////////////////////////////////////////////////////////////
	// Word for the current step

	always_comb begin
		// Boot power word
		reg_addr  = reg_power;
		reg_wdata = 16'hffff;
		reg_wmask = '0;
		if (!boot_write) begin
			if (cmd_kind == cmd_vco) begin
				case (step)
					3'd0: begin
						reg_addr  = reg_clkfbout_1;
						reg_wdata = clkreg1_word(3'd0, {1'b0, vco_mult});
						reg_wmask = mask_clkreg1;
					end
					3'd1: begin
						reg_addr  = reg_clkfbout_2;
						reg_wdata = clkreg2_word({1'b0, vco_mult}, 6'd0);
						reg_wmask = mask_clkfbout_2;
					end
					3'd2: begin
						reg_addr  = reg_indiv;
						reg_wdata = indiv_word;
						reg_wmask = mask_indiv;
					end
					3'd3: begin
						reg_addr  = reg_lock_1;
						reg_wdata = {6'd0, lock_cnt};
						reg_wmask = mask_lock_1;
					end
					// Same delay feeds both lock registers
					3'd4: begin
						reg_addr  = reg_lock_2;
						reg_wdata = {1'b0, lock_dly, unlock_cnt};
						reg_wmask = mask_lock_23;
					end
					3'd5: begin
						reg_addr  = reg_lock_3;
						reg_wdata = {1'b0, lock_dly, lock_sat_high};
						reg_wmask = mask_lock_23;
					end
					3'd6: begin
						reg_addr  = reg_filt_1;
						reg_wdata = filt1_word;
						reg_wmask = mask_filt_1;
					end
					default: begin
						reg_addr  = reg_filt_2;
						reg_wdata = filt2_word;
						reg_wmask = mask_filt_2;
					end
				endcase
			end else if (step == 3'd0) begin
				// Fine phase in register 1
				reg_addr  = out_addr_1;
				reg_wdata = clkreg1_word(output_phase[2:0], output_div);
				reg_wmask = mask_clkreg1;
			end else begin
				// Coarse phase as delay in register 2
				reg_addr  = out_addr_2;
				reg_wdata = clkreg2_word(output_div, output_phase[8:3]);
				reg_wmask = out_mask_2;
			end
		end
	end

endmodule

`default_nettype wire

//--- pll_lock_table.sv
`timescale 1ns/1ps
`default_nettype none

module pll_lock_table import pll_reconfig_pkg::*; (
	input wire [6:0]   vco_mult,
	output logic [9:0] lock_cnt,
	output logic [4:0] lock_dly,
	output logic [7:0] filter_lo,
	output logic [7:0] filter_hi
);

	// Hex words of lock count 22:13, reference delay 12:8, filter 7:0
	logic [22:0] lock_rom [lock_table_depth];
	logic [5:0]  rom_addr;
	logic [22:0] rom_word;

	initial begin
		$readmemh("pll_lock_table.mem", lock_rom);
	end

	// Entry 0 holds multiplier 1
	assign rom_addr = 6'(vco_mult - 7'd1);
	assign rom_word = lock_rom[rom_addr];

	assign lock_cnt  = rom_word[22:13];
	assign lock_dly  = rom_word[12:8];
	assign filter_lo = rom_word[7:0];
	// High bandwidth forces the upper filter bits
	assign filter_hi = {4'hf, rom_word[3:0]};

endmodule

`default_nettype wire

//--- pll_reconfig_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_ctrl import pll_reconfig_pkg::*; (
	input wire            reconfig_clk,
	input wire            reset,
	input wire            reconfig_start,
	input wire            reconfig_finish,
	output logic          busy,
	output logic          reconfig_cmd_done,
	input wire            vco_en,
	input wire [6:0]      vco_mult,
	input wire [6:0]      vco_indiv,
	input wire            vco_bandwidth,
	input wire            output_en,
	input wire [2:0]      output_idx,
	input wire [7:0]      output_div,
	input wire [8:0]      output_phase,
	output logic          pll_reset,
	output logic          drp_en,
	output logic          drp_we,
	output drp_addr_t     drp_addr,
	output drp_word_t     drp_din,
	input wire drp_word_t drp_dout,
	input wire            drp_ready
);

	logic       reg_wr;
	logic       reg_wr_done;
	logic       step_load;
	logic       boot_write;
	logic [2:0] step;
	logic       last_step;
	cmd_kind_e  cmd_kind;
	drp_addr_t  reg_addr;
	drp_word_t  reg_wdata;
	drp_word_t  reg_wmask;
	logic [9:0] lock_cnt;
	logic [4:0] lock_dly;
	logic [7:0] filter_lo;
	logic [7:0] filter_hi;

	////////////////////////////////////////////////////////////
	// Control

	reconfig_sequencer reconfig_sequencer_inst (
		.reconfig_clk      (reconfig_clk),
		.reset             (reset),
		.reconfig_start    (reconfig_start),
		.reconfig_finish   (reconfig_finish),
		.vco_en            (vco_en),
		.output_en         (output_en),
		.reg_wr_done       (reg_wr_done),
		.last_step         (last_step),
		.busy              (busy),
		.reconfig_cmd_done (reconfig_cmd_done),
		.pll_reset         (pll_reset),
		.reg_wr            (reg_wr),
		.step_load         (step_load),
		.cmd_kind          (cmd_kind),
		.boot_write        (boot_write)
	);

	write_step_counter write_step_counter_inst (
		.reconfig_clk (reconfig_clk),
		.reset        (reset),
		.step_load    (step_load),
		.cmd_kind     (cmd_kind),
		.reg_wr_done  (reg_wr_done),
		.step         (step),
		.last_step    (last_step)
	);

	////////////////////////////////////////////////////////////
	// Register words

	pll_lock_table pll_lock_table_inst (
		.vco_mult  (vco_mult),
		.lock_cnt  (lock_cnt),
		.lock_dly  (lock_dly),
		.filter_lo (filter_lo),
		.filter_hi (filter_hi)
	);

	drp_word_builder drp_word_builder_inst (
		.cmd_kind      (cmd_kind),
		.step          (step),
		.boot_write    (boot_write),
		.vco_mult      (vco_mult),
		.vco_indiv     (vco_indiv),
		.vco_bandwidth (vco_bandwidth),
		.output_idx    (output_idx),
		.output_div    (output_div),
		.output_phase  (output_phase),
		.lock_cnt      (lock_cnt),
		.lock_dly      (lock_dly),
		.filter_lo     (filter_lo),
		.filter_hi     (filter_hi),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.reg_wmask     (reg_wmask)
	);

	// Register port
	drp_rmw_engine drp_rmw_engine_inst (
		.reconfig_clk (reconfig_clk),
		.reset        (reset),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_wmask    (reg_wmask),
		.drp_dout     (drp_dout),
		.drp_ready    (drp_ready),
		.reg_wr_done  (reg_wr_done),
		.drp_en       (drp_en),
		.drp_we       (drp_we),
		.drp_addr     (drp_addr),
		.drp_din      (drp_din)
	);

endmodule

`default_nettype wire

//--- tb_drp_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_drp_model import pll_reconfig_pkg::*; (
	input wire            reconfig_clk,
	input wire            drp_en,
	input wire            drp_we,
	input wire drp_addr_t drp_addr,
	input wire drp_word_t drp_din,
	output drp_word_t     drp_dout,
	output logic          drp_ready
);

	// Full register file of the PLL
	drp_word_t regs [128];

	// Access waiting for its answer
	drp_addr_t pend_addr;
	drp_word_t pend_din;
	logic      pend_we;
	int        wait_cycles;

	initial begin
		drp_ready   = 1'b0;
		drp_dout    = '0;
		pend_we     = 1'b0;
		wait_cycles = 0;
	end

	// Power-up contents, called once the seed is set
	task automatic fill_random();
		for (int i = 0; i < 128; i++)
			regs[i] = drp_word_t'($urandom);
	endtask

	////////////////////////////////////////////////////////////
	// Access and answer after 1 to 4 cycles

	always @(posedge reconfig_clk) begin
		drp_ready <= 1'b0;
		if (drp_en === 1'b1) begin
			pend_addr   <= drp_addr;
			pend_we     <= drp_we;
			pend_din    <= drp_din;
			wait_cycles <= $urandom_range(1, 4);
		end else if (wait_cycles > 0) begin
			// Answer goes out with the data
			if (wait_cycles == 1) begin
				drp_ready <= 1'b1;
				if (pend_we)
					regs[pend_addr] <= pend_din;
				else
					drp_dout <= regs[pend_addr];
			end
			wait_cycles <= wait_cycles - 1;
		end
	end

endmodule

`default_nettype wire

//--- tb_pll_reconfig_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pll_reconfig_ctrl import pll_reconfig_pkg::*; ();

	localparam int timeout_cycles = 400;
	localparam int quiet_cycles   = 40;
	localparam int sel_busy       = 0;
	localparam int sel_done       = 1;
	localparam int sel_pll_reset  = 2;

	logic       reconfig_clk;
	logic       reset;
	logic       reconfig_start;
	logic       reconfig_finish;
	logic       busy;
	logic       reconfig_cmd_done;
	logic       vco_en;
	logic [6:0] vco_mult;
	logic [6:0] vco_indiv;
	logic       vco_bandwidth;
	logic       output_en;
	logic [2:0] output_idx;
	logic [7:0] output_div;
	logic [8:0] output_phase;
	logic       pll_reset;
	logic       drp_en;
	logic       drp_we;
	drp_addr_t  drp_addr;
	drp_word_t  drp_din;
	drp_word_t  drp_dout;
	logic       drp_ready;

	// Reference lock table and register snapshot
	logic [22:0] lock_mem [64];
	drp_word_t   prior [128];

	// Expected writes of the current test
	drp_addr_t exp_addr [8];
	drp_word_t exp_data [8];
	drp_word_t exp_mask [8];
	int        exp_n;
	logic      exp_pll_reset;

	// Bookkeeping
	int   test_errors;
	int   total_errors;
	int   tests_run;
	int   tests_failed;
	logic timed_out;
	int   en_count;
	int   we_count;
	int   done_count;
	int   pair_errors;
	logic write_next;

	pll_reconfig_ctrl pll_reconfig_ctrl_inst (
		.reconfig_clk      (reconfig_clk),
		.reset             (reset),
		.reconfig_start    (reconfig_start),
		.reconfig_finish   (reconfig_finish),
		.busy              (busy),
		.reconfig_cmd_done (reconfig_cmd_done),
		.vco_en            (vco_en),
		.vco_mult          (vco_mult),
		.vco_indiv         (vco_indiv),
		.vco_bandwidth     (vco_bandwidth),
		.output_en         (output_en),
		.output_idx        (output_idx),
		.output_div        (output_div),
		.output_phase      (output_phase),
		.pll_reset         (pll_reset),
		.drp_en            (drp_en),
		.drp_we            (drp_we),
		.drp_addr          (drp_addr),
		.drp_din           (drp_din),
		.drp_dout          (drp_dout),
		.drp_ready         (drp_ready)
	);

	tb_drp_model drp_model_inst (
		.reconfig_clk (reconfig_clk),
		.drp_en       (drp_en),
		.drp_we       (drp_we),
		.drp_addr     (drp_addr),
		.drp_din      (drp_din),
		.drp_dout     (drp_dout),
		.drp_ready    (drp_ready)
	);

	initial begin
		reconfig_clk = 1'b0;
		forever #10 reconfig_clk = ~reconfig_clk;
	end

	////////////////////////////////////////////////////////////
	// Port monitor, reads in pairs with the write second

	always @(negedge reconfig_clk) begin
		if (drp_en === 1'b1) begin
			en_count++;
			if (drp_we === 1'b1)
				we_count++;
			if (drp_we !== write_next)
				pair_errors++;
			write_next = ~write_next;
		end else if (drp_we === 1'b1) begin
			pair_errors++;
		end
		if (reconfig_cmd_done === 1'b1)
			done_count++;
	end

	task automatic clear_counts();
		en_count    = 0;
		we_count    = 0;
		done_count  = 0;
		pair_errors = 0;
		write_next  = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_word(input string what, input drp_word_t actual, input drp_word_t expected);
		if (actual !== expected) begin
			$display("MISMATCH %0t: %s is %h, expected %h", $time, what, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("MISMATCH %0t: %s is %b, expected %b", $time, what, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_count(input string what, input int actual, input int expected);
		if (actual != expected) begin
			$display("MISMATCH %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			test_errors++;
		end
	endtask

	// Polls one output at the falling edge until it reaches the level
	task automatic wait_level(input int sel, input logic level, input string what);
		int   n;
		logic v;
		n = 0;
		v = ~level;
		while (v !== level && n < timeout_cycles) begin
			@(negedge reconfig_clk);
			case (sel)
				sel_busy: v = busy;
				sel_done: v = reconfig_cmd_done;
				default:  v = pll_reset;
			endcase
			n++;
		end
		if (v !== level) begin
			$display("Timeout at %0t while waiting for %s", $time, what);
			test_errors++;
			timed_out = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Expected register words

	// High count then low count, low one longer for odd divisors
	function automatic logic [11:0] half_counts(input logic [7:0] div);
		logic [5:0] high;
		logic [5:0] low;
		high = 6'(div / 2);
		low  = 6'(div / 2 + div % 2);
		return {high, low};
	endfunction

	task automatic expect_write(input drp_addr_t addr, input drp_word_t data, input drp_word_t mask);
		exp_addr[exp_n] = addr;
		exp_data[exp_n] = data;
		exp_mask[exp_n] = mask;
		exp_n++;
	endtask

	task automatic plan_vco(input logic [6:0] mult, input logic [6:0] indiv, input logic bw);
		logic [22:0] entry;
		logic [9:0]  cnt;
		logic [4:0]  dly;
		logic [7:0]  filt;
		entry = lock_mem[mult - 7'd1];
		cnt   = entry[22:13];
		dly   = entry[12:8];
		// High bandwidth forces the upper filter nibble
		filt  = bw ? {4'hf, entry[3:0]} : entry[7:0];
		exp_n = 0;
		expect_write(7'h14, {4'h0, half_counts({1'b0, mult})}, 16'h1000);
		expect_write(7'h15, {8'h00, mult[0], mult == 7'd1, 6'h00}, 16'h8000);
		expect_write(7'h16, {2'b00, indiv[0], indiv == 7'd1, half_counts({1'b0, indiv})},
			16'hc000);
		expect_write(7'h18, {6'h00, cnt}, 16'hfc00);
		expect_write(7'h19, {1'b0, dly, 10'd1}, 16'h8000);
		expect_write(7'h1a, {1'b0, dly, 10'h3e9}, 16'h8000);
		expect_write(7'h4e, {filt[7], 2'b00, filt[6:5], 2'b00, filt[4], 8'h00}, 16'h66ff);
		expect_write(7'h4f, {filt[3], 2'b00, filt[2:1], 2'b00, filt[0], 8'h00}, 16'h666f);
	endtask

	task automatic plan_out(input logic [2:0] idx, input logic [7:0] div, input logic [8:0] phase);
		drp_addr_t base;
		drp_word_t mask2;
		case (idx)
			3'd1:    base = 7'h0a;
			3'd2:    base = 7'h0c;
			3'd3:    base = 7'h0e;
			3'd4:    base = 7'h10;
			3'd5:    base = 7'h06;
			default: base = 7'h08;
		endcase
		// Register 2 keeps more bits on outputs 1 to 5
		if (idx == 3'd5)
			mask2 = 16'hc000;
		else if (idx >= 3'd1 && idx <= 3'd4)
			mask2 = 16'hfc00;
		else
			mask2 = 16'h8000;
		exp_n = 0;
		expect_write(base, {phase[2:0], 1'b0, half_counts(div)}, 16'h1000);
		expect_write(base + 7'd1, {8'h00, div[0], div == 8'd1, phase[8:3]}, mask2);
	endtask

	////////////////////////////////////////////////////////////
	// Host side drivers

	task automatic issue_command(input string kind, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c);
		@(posedge reconfig_clk);
		if (kind == "vco") begin
			vco_mult      <= a[6:0];
			vco_indiv     <= b[6:0];
			vco_bandwidth <= c[0];
			vco_en        <= 1'b1;
		end else begin
			output_idx   <= a[2:0];
			output_div   <= b[7:0];
			output_phase <= c[8:0];
			output_en    <= 1'b1;
		end
		@(posedge reconfig_clk);
		vco_en    <= 1'b0;
		output_en <= 1'b0;
	endtask

	task automatic pulse_mode(input logic enter);
		@(posedge reconfig_clk);
		if (enter)
			reconfig_start <= 1'b1;
		else
			reconfig_finish <= 1'b1;
		@(posedge reconfig_clk);
		reconfig_start  <= 1'b0;
		reconfig_finish <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// One stimulus line

	task automatic run_test(input string kind, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c, input int writes, input string name);
		logic      is_cmd;
		drp_addr_t addr;
		drp_word_t want;
		test_errors = 0;
		exp_n       = 0;
		is_cmd      = (kind == "vco" || kind == "out");
		// Boot write counts from reset
		if (kind != "boot")
			clear_counts();
		for (int i = 0; i < 128; i++)
			prior[i] = drp_model_inst.regs[i];

		case (kind)
			"boot": begin
				expect_write(7'h28, 16'hffff, 16'h0000);
				wait_level(sel_busy, 1'b0, "busy to fall after boot");
			end
			"start": begin
				exp_pll_reset = 1'b1;
				pulse_mode(1'b1);
				wait_level(sel_pll_reset, 1'b1, "pll_reset to rise");
			end
			"finish": begin
				exp_pll_reset = 1'b0;
				pulse_mode(1'b0);
				wait_level(sel_pll_reset, 1'b0, "pll_reset to fall");
			end
			"vco", "out": begin
				if (kind == "vco")
					plan_vco(a[6:0], b[6:0], c[0]);
				else
					plan_out(a[2:0], b[7:0], c[8:0]);
				issue_command(kind, a, b, c);
				// Ignored commands leave the port quiet
				if (writes > 0)
					wait_level(sel_done, 1'b1, {"reconfig_cmd_done of ", name});
				else
					repeat (quiet_cycles) @(negedge reconfig_clk);
			end
			default: begin
				$display("Unknown command kind %s in test %s", kind, name);
				test_errors++;
			end
		endcase
		repeat (4) @(negedge reconfig_clk);

		// Merged words, or nothing changed at all
		if (writes == 0) begin
			for (int i = 0; i < 128; i++)
				check_word($sformatf("%s register %h", name, i), drp_model_inst.regs[i], prior[i]);
		end else begin
			for (int i = 0; i < exp_n; i++) begin
				addr = exp_addr[i];
				want = (prior[addr] & exp_mask[i]) | (exp_data[i] & ~exp_mask[i]);
				check_word($sformatf("%s register %h", name, addr), drp_model_inst.regs[addr], want);
			end
		end

		check_count({name, " drp_en pulses"}, en_count, 2 * writes);
		check_count({name, " drp_we pulses"}, we_count, writes);
		check_count({name, " read/write pairing errors"}, pair_errors, 0);
		check_count({name, " reconfig_cmd_done pulses"}, done_count, (is_cmd && writes > 0) ? 1 : 0);
		check_flag({name, " busy"}, busy, 1'b0);
		check_flag({name, " pll_reset"}, pll_reset, exp_pll_reset);

		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %-20s %s", name, (test_errors == 0) ? "passed" : "failed");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int          fd;
		int          fields;
		string       line;
		string       kind;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int          writes;

		reset           = 1'b1;
		reconfig_start  = 1'b0;
		reconfig_finish = 1'b0;
		vco_en          = 1'b0;
		vco_mult        = 7'd1;
		vco_indiv       = 7'd1;
		vco_bandwidth   = 1'b0;
		output_en       = 1'b0;
		output_idx      = 3'd0;
		output_div      = 8'd1;
		output_phase    = 9'd0;
		exp_pll_reset   = 1'b1;
		total_errors    = 0;
		tests_run       = 0;
		tests_failed    = 0;
		timed_out       = 1'b0;

		void'($urandom(32'hf232_48db));
		drp_model_inst.fill_random();
		$readmemh("pll_lock_table.mem", lock_mem);
		clear_counts();

		repeat (4) @(posedge reconfig_clk);
		reset <= 1'b0;

		fd = $fopen("pll_reconfig_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file pll_reconfig_stim.txt");
			total_errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank and comment lines
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%s %h %h %h %d %s", kind, a, b, c, writes, name);
				if (fields != 6) begin
					$display("Malformed stimulus line: %s", line);
					total_errors++;
					continue;
				end
				run_test(kind, a, b, c, writes, name);
			end
			$fclose(fd);
		end

		$display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errors);
		if (total_errors == 0 && tests_run > 0 && !timed_out) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- pll_lock_table.mem
// Lock table, entry n holds multiplier n+1
// Lock count [22:13], reference delay [12:8], low-bandwidth filter [7:0]
7D0107
7C015A
7B01AD
7A01F0
790243
780296
7702E9
76023C
75038F
7403D2
730325
720378
7104CB
70041E
6F0461
6E04B4
6D0507
6C055A
6B05AD
6A05F0
690643
680696
6706E9
66063C
65078F
6407D2
630725
620778
6108CB
60081E
5F0861
5E08B4
5D0907
5C095A
5B09AD
5A09F0
590A43
580A96
570AE9
560A3C
550B8F
540BD2
530B25
520B78
510CCB
500C1E
4F0C61
4E0CB4
4D0D07
4C0D5A
4B0DAD
4A0DF0
490E43
480E96
470EE9
460E3C
450F8F
440FD2
430F25
420F78
4110CB
40101E
3F1061
3E10B4

//--- pll_reconfig_stim.txt
# kind a b c writes name; a b c in hex, writes in decimal
# vco: a mult, b input divider, c bandwidth; out: a index, b divider, c phase
boot   0  0   0   1 boot_power_write
out    0  5   1a  0 out_before_mode
start  0  0   0   0 mode_entry
vco    10 1   0   8 vco_even_low_bw
vco    7  3   1   8 vco_odd_high_bw
vco    1  1   1   8 vco_mult_one
vco    40 2   0   8 vco_mult_max
out    0  5   1a  2 out0_odd_div
out    3  4   5b  2 out3_even_div
out    5  1   1ff 2 out5_div_one
finish 0  0   0   0 mode_exit
vco    10 5   1   0 vco_after_mode
start  0  0   0   0 mode_reentry
finish 0  0   0   0 mode_exit_again

//--- sources.f
pll_reconfig_pkg.sv
drp_rmw_engine.sv
reconfig_sequencer.sv
write_step_counter.sv
drp_word_builder.sv
pll_lock_table.sv
pll_reconfig_ctrl.sv
tb_drp_model.sv
tb_pll_reconfig_ctrl.sv
